// File: src.f
+incdir+common
common/op_pkg.sv
common/pipe_pkg.sv
common/stage_if.sv
src/exe_stage.sv
src/mul_unit.sv
mem/mem_stage.sv
mem/data_sram.sv
src/wb_stage.sv
src/pipe_backend_top.sv
dv/tb_clkgen.sv
dv/tb_top.sv

// File: Makefile
SIM  := obj_dir/Vtb_top
SRCS := $(wildcard common/*.sv common/*.svh src/*.sv mem/*.sv dv/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module tb_top --Mdir obj_dir -f src.f

clean:
	rm -rf obj_dir

// File: dv/tb_top.sv
`include "pipe_params.svh"

module tb_top
    import op_pkg::*, pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD      = 8;
    localparam int          DRIVE_DLY       = 1;
    localparam int          N_INSTR         = 400;
    localparam int          N_WIN_WORDS     = 16;   // Loads and stores stay inside this window.
    localparam int          WATCHDOG_CYCLES = 4 * N_INSTR + 64;
    localparam int          DRAIN_LIMIT     = 64;
    localparam logic [31:0] WIN_BASE        = 32'h0000_0100;
    localparam logic [31:0] PC_BASE         = 32'h1c00_0000;

    logic                     clk;
    logic                     resetn;
    logic                     in_valid;
    logic                     in_allowin;
    logic [`PIPE_XLEN-1:0]    in_pc;
    inst_class_e              in_cls;
    op_u                      in_op;
    logic [`PIPE_XLEN-1:0]    in_rj_val;
    logic [`PIPE_XLEN-1:0]    in_rk_val;
    logic [`PIPE_XLEN-1:0]    in_imm;
    logic [`PIPE_RADDR_W-1:0] in_dest;
    logic                     out_ready;
    logic                     wb_valid;
    logic [`PIPE_XLEN-1:0]    wb_pc;
    logic                     wb_rf_we;
    logic [`PIPE_RADDR_W-1:0] wb_rf_waddr;
    logic [`PIPE_XLEN-1:0]    wb_rf_wdata;

    int          seed = 32'h8b5c;
    mem_wb_t     exp_q[$];                       // Retirements still owed, in program order.
    logic [7:0]  shadow [0:4*N_WIN_WORDS-1];

    tb_clkgen #(.PERIOD(CLK_PERIOD)) clkgen0 (
        .clk    (clk),
        .resetn (resetn)
    );

    pipe_backend_top dut0 (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_pc       (in_pc),
        .in_cls      (in_cls),
        .in_op       (in_op),
        .in_rj_val   (in_rj_val),
        .in_rk_val   (in_rk_val),
        .in_imm      (in_imm),
        .in_dest     (in_dest),
        .out_ready   (out_ready),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rf_we    (wb_rf_we),
        .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            default:  return a >> b[4:0];     // Logical right shift.
        endcase
    endfunction

    function automatic logic [31:0] mul_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'd0, a} * {32'd0, b};
        case (op)
            MUL_LO:  return uprod[31:0];
            MUL_H:   return sprod[63:32];
            default: return uprod[63:32];
        endcase
    endfunction

    // Byte lane i of a little-endian word is bits i*8+7 down to i*8.
    function automatic logic [31:0] load_model(input logic [31:0] addr, input mem_size_e size,
                                               input logic zero_ext);
        int          off;
        logic [31:0] word;
        off = int'(addr - WIN_BASE);
        case (size)
            SZ_BYTE: begin
                word = {24'd0, shadow[off]};
                if (!zero_ext) word[31:8] = {24{shadow[off][7]}};
            end
            SZ_HALF: begin
                word = {16'd0, shadow[off + 1], shadow[off]};
                if (!zero_ext) word[31:16] = {16{shadow[off + 1][7]}};
            end
            default: word = {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
        endcase
        return word;
    endfunction

    task automatic write_shadow(input logic [31:0] addr, input mem_size_e size,
                                input logic [31:0] data);
        int off;
        off = int'(addr - WIN_BASE);
        shadow[off] = data[7:0];
        if (size != SZ_BYTE) begin
            shadow[off + 1] = data[15:8];
        end
        if (size == SZ_WORD) begin
            shadow[off + 2] = data[23:16];
            shadow[off + 3] = data[31:24];
        end
    endtask

    // Called once for each instruction the top level accepts.
    task automatic predict_retire();
        mem_wb_t     exp;
        logic [31:0] addr;
        addr         = in_rj_val + in_imm;
        exp.pc       = in_pc;
        exp.rf_we    = (in_cls != CLS_STORE) && (in_dest != '0);
        exp.rf_waddr = in_dest;
        case (in_cls)
            CLS_ALU:  exp.rf_wdata = alu_model(in_op.alu, in_rj_val, in_rk_val);
            CLS_MUL:  exp.rf_wdata = mul_model(in_op.alu, in_rj_val, in_rk_val);
            CLS_LOAD: exp.rf_wdata = load_model(addr, in_op.mem.size, in_op.mem.zero_ext);
            default: begin
                write_shadow(addr, in_op.mem.size, in_rk_val);
                exp.rf_wdata = addr;  // A store retires with its address.
            end
        endcase
        exp_q.push_back(exp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic build_instr(input int idx);
        int          kind;
        int          sz;
        int          word_idx;
        int          off;
        int          pick;
        logic        ze;
        logic [31:0] addr;
        in_pc     = PC_BASE + 32'(idx) * 4;
        in_rj_val = $random(seed);
        in_rk_val = $random(seed);
        in_dest   = (($random(seed) & 7) == 0) ? 5'd0 : 5'($random(seed));
        in_imm    = $random(seed);
        in_op     = '0;
        // The first instructions fill the window with word stores.
        kind = (idx < N_WIN_WORDS) ? 14 : int'($unsigned($random(seed)) % 20);
        if (kind < 7) begin
            pick = $unsigned($random(seed)) % 9;
            in_cls = CLS_ALU;
            in_op.alu = alu_op_e'(pick[3:0]);
            if (($random(seed) & 7) == 0) in_rk_val = in_rj_val;
        end else if (kind < 17) begin
            sz       = (idx < N_WIN_WORDS) ? 2 : int'($unsigned($random(seed)) % 3);
            word_idx = (idx < N_WIN_WORDS) ? idx : ($random(seed) & 15);
            off      = (sz == 0) ? ($random(seed) & 3) : (sz == 1) ? 2 * ($random(seed) & 1) : 0;
            ze       = (kind < 12) && (sz != 2) && (($random(seed) & 1) != 0);
            addr     = WIN_BASE + 32'(word_idx * 4 + off);
            in_cls   = (kind < 12) ? CLS_LOAD : CLS_STORE;
            in_imm   = addr - in_rj_val;
            in_op.mem = '{spare: 1'b0, zero_ext: ze, size: mem_size_e'(sz[1:0])};
        end else begin
            pick = $unsigned($random(seed)) % 3;
            in_cls = CLS_MUL;
            in_op.alu = (pick == 0) ? MUL_LO : (pick == 1) ? MUL_H : MUL_HU;
        end
        in_valid = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, sig, exp, act);
        stop_on_failure();
    endtask

    task automatic compare_wb(input mem_wb_t exp, input mem_wb_t act);
        if (act.pc !== exp.pc)
            report_mismatch("wb_pc", exp.pc, act.pc);
        else if (act.rf_we !== exp.rf_we)
            report_mismatch("wb_rf_we", 32'(exp.rf_we), 32'(act.rf_we));
        else if (act.rf_waddr !== exp.rf_waddr)
            report_mismatch("wb_rf_waddr", 32'(exp.rf_waddr), 32'(act.rf_waddr));
        else if (act.rf_wdata !== exp.rf_wdata)
            report_mismatch("wb_rf_wdata", exp.rf_wdata, act.rf_wdata);
    endtask

    // Outputs are stable at the falling edge; the retirement completes at the next rise.
    always @(negedge clk) begin : check_retire
        mem_wb_t got;
        if (resetn && wb_valid && out_ready) begin
            got = '{pc: wb_pc, rf_we: wb_rf_we, rf_waddr: wb_rf_waddr, rf_wdata: wb_rf_wdata};
            if (exp_q.size() == 0) begin
                $display("Unexpected retirement of pc %h at %0t ns with nothing outstanding",
                         wb_pc, $time);
                stop_on_failure();
            end else begin
                compare_wb(exp_q.pop_front(), got);
            end
        end
    end

    initial begin : drive_stimulus
        int   n;
        int   drain;
        logic took;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_cls    = CLS_ALU;
        in_op     = '0;
        in_rj_val = '0;
        in_rk_val = '0;
        in_imm    = '0;
        in_dest   = '0;
        out_ready = 1'b1;
        n         = 0;
        wait (resetn);
        @(posedge clk);
        #DRIVE_DLY;
        build_instr(n);
        while (n < N_INSTR) begin
            @(negedge clk);
            took = in_valid && in_allowin;
            if (took) begin
                predict_retire();
                n++;
            end
            @(posedge clk);
            #DRIVE_DLY;
            out_ready = (($random(seed) & 3) != 0);    // Stalls about a quarter of cycles.
            if (took || !in_valid) begin
                if (n < N_INSTR && (($random(seed) & 7) != 0))
                    build_instr(n);
                else
                    in_valid = 1'b0;
            end
        end
        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            out_ready = (($random(seed) & 3) != 0);
            drain++;
        end
        out_ready = 1'b1;
        repeat (4) @(posedge clk);    // Room for a spurious extra retirement to show.
        if (exp_q.size() != 0) begin
            $display("Missing retirement, %0d instructions never left write-back, next pc %h",
                     exp_q.size(), exp_q[0].pc);
            stop_on_failure();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

// File: dv/tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD = 8
) (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is sampled low at the first two rising edges.
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

// File: src/pipe_backend_top.sv
`include "pipe_params.svh"

module pipe_backend_top
    import op_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  logic [`PIPE_XLEN-1:0]    in_pc,
    input  inst_class_e              in_cls,
    input  op_u                      in_op,
    input  logic [`PIPE_XLEN-1:0]    in_rj_val,
    input  logic [`PIPE_XLEN-1:0]    in_rk_val,
    input  logic [`PIPE_XLEN-1:0]    in_imm,
    input  logic [`PIPE_RADDR_W-1:0] in_dest,
    input  logic                     out_ready,
    output logic                     wb_valid,
    output logic [`PIPE_XLEN-1:0]    wb_pc,
    output logic                     wb_rf_we,
    output logic [`PIPE_RADDR_W-1:0] wb_rf_waddr,
    output logic [`PIPE_XLEN-1:0]    wb_rf_wdata
);

    logic                    sram_en;
    logic [3:0]              sram_we;
    logic [`DSRAM_AW-1:0]    sram_addr;
    logic [`PIPE_XLEN-1:0]   sram_wdata;
    logic [`PIPE_XLEN-1:0]   sram_rdata;
    logic [`PIPE_XLEN-1:0]   mul_a;
    logic [`PIPE_XLEN-1:0]   mul_b;
    logic                    mul_signed;
    logic                    mul_go;
    logic [2*`PIPE_XLEN-1:0] mul_result;

    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    exe_stage u_exe (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_pc      (in_pc),
        .in_cls     (in_cls),
        .in_op      (in_op),
        .in_rj_val  (in_rj_val),
        .in_rk_val  (in_rk_val),
        .in_imm     (in_imm),
        .in_dest    (in_dest),
        .ex_mem     (ex_mem.master),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .mul_signed (mul_signed),
        .mul_go     (mul_go)
    );

    mul_unit u_mul (
        .clk        (clk),
        .mul_go     (mul_go),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .mul_signed (mul_signed),
        .mul_result (mul_result)
    );

    data_sram u_dsram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    mem_stage u_mem (
        .clk        (clk),
        .resetn     (resetn),
        .ex_mem     (ex_mem.slave),
        .mem_wb     (mem_wb.master),
        .sram_rdata (sram_rdata),
        .mul_result (mul_result)
    );

    wb_stage u_wb (
        .clk         (clk),
        .resetn      (resetn),
        .mem_wb      (mem_wb.slave),
        .out_ready   (out_ready),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rf_we    (wb_rf_we),
        .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata)
    );

endmodule

// File: src/wb_stage.sv
`include "pipe_params.svh"

module wb_stage
    import pipe_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    mem_wb_if.slave                  mem_wb,
    input  logic                     out_ready,
    output logic                     wb_valid,
    output logic [`PIPE_XLEN-1:0]    wb_pc,
    output logic                     wb_rf_we,
    output logic [`PIPE_RADDR_W-1:0] wb_rf_waddr,
    output logic [`PIPE_XLEN-1:0]    wb_rf_wdata
);

    mem_wb_t wb_r;

    assign mem_wb.allowin = ~wb_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (mem_wb.allowin) begin
            wb_valid <= mem_wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb.valid && mem_wb.allowin) begin
            wb_r <= mem_wb.data;
        end
    end

    assign wb_pc       = wb_r.pc;
    assign wb_rf_we    = wb_r.rf_we;
    assign wb_rf_waddr = wb_r.rf_waddr;
    assign wb_rf_wdata = wb_r.rf_wdata;

    // The memory stage must keep offering the same retirement until this stage takes it.
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        mem_wb.valid && !mem_wb.allowin |=> mem_wb.valid && $stable(mem_wb.data))
        else $error("memory stage output changed while write-back was stalled");

endmodule

// File: mem/data_sram.sv
`include "pipe_params.svh"

module data_sram (
    input  logic                  clk,
    input  logic                  en,
    input  logic [3:0]            we,
    input  logic [`DSRAM_AW-1:0]  addr,
    input  logic [`PIPE_XLEN-1:0] wdata,
    output logic [`PIPE_XLEN-1:0] rdata
);

    logic [`PIPE_XLEN-1:0] ram [0:(1 << `DSRAM_AW)-1];

    // Read returns the old word when the same cycle writes it.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= ram[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    ram[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// File: mem/mem_stage.sv
`include "pipe_params.svh"

module mem_stage
    import op_pkg::*, pipe_pkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    ex_mem_if.slave                   ex_mem,
    mem_wb_if.master                  mem_wb,
    input  logic [`PIPE_XLEN-1:0]     sram_rdata,
    input  logic [2*`PIPE_XLEN-1:0]   mul_result
);

    logic                  mem_valid;
    logic                  mem_allowin;
    logic                  mem_first;   // First cycle of the current instruction.
    ex_mem_t               mem_r;
    logic [`PIPE_XLEN-1:0] rdata_hold;
    logic [`PIPE_XLEN-1:0] rdata_sel;
    logic [`PIPE_XLEN-1:0] shift_rdata;
    logic [`PIPE_XLEN-1:0] load_result;
    logic [`PIPE_XLEN-1:0] rf_wdata;
    logic                  sext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign mem_allowin    = ~mem_valid | mem_wb.allowin;
    assign ex_mem.allowin = mem_allowin;
    assign mem_wb.valid   = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            mem_first <= 1'b0;
        end else begin
            mem_first <= ex_mem.valid & mem_allowin;
            if (mem_allowin) begin
                mem_valid <= ex_mem.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && mem_allowin) begin
            mem_r <= ex_mem.data;
        end
    end

    // SRAM data is only good in the first cycle. Keep it for a stall.
    always_ff @(posedge clk) begin
        if (mem_first) begin
            rdata_hold <= sram_rdata;
        end
    end

    assign rdata_sel = mem_first ? sram_rdata : rdata_hold;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load alignment and result select.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign shift_rdata = rdata_sel >> {mem_r.alu_result[1:0], 3'b000};
    assign sext        = ~mem_r.op.mem.zero_ext;

    always_comb begin
        case (mem_r.op.mem.size)
            SZ_BYTE: load_result = {{24{sext & shift_rdata[7]}}, shift_rdata[7:0]};
            SZ_HALF: load_result = {{16{sext & shift_rdata[15]}}, shift_rdata[15:0]};
            default: load_result = shift_rdata;
        endcase
    end

    always_comb begin
        case (mem_r.cls)
            CLS_LOAD: rf_wdata = load_result;
            CLS_MUL:  rf_wdata = mem_r.mul_high ? mul_result[2*`PIPE_XLEN-1:`PIPE_XLEN]
                                                : mul_result[`PIPE_XLEN-1:0];
            default:  rf_wdata = mem_r.alu_result;  // Stores retire their address.
        endcase
    end

    assign mem_wb.data = '{
        pc:       mem_r.pc,
        rf_we:    mem_r.rf_we,
        rf_waddr: mem_r.rf_waddr,
        rf_wdata: rf_wdata
    };

    // Catches a product or read word that never arrived in step with its payload.
    a_known: assert property (@(posedge clk) disable iff (!resetn)
        mem_wb.valid |-> !$isunknown(mem_wb.data))
        else $error("unknown payload leaving memory stage, pc %h", mem_r.pc);

endmodule

// File: src/mul_unit.sv
`include "pipe_params.svh"

module mul_unit (
    input  logic                     clk,
    input  logic                     mul_go,
    input  logic [`PIPE_XLEN-1:0]    mul_a,
    input  logic [`PIPE_XLEN-1:0]    mul_b,
    input  logic                     mul_signed,
    output logic [2*`PIPE_XLEN-1:0]  mul_result
);

    logic signed [`PIPE_XLEN:0]     a_ext;
    logic signed [`PIPE_XLEN:0]     b_ext;
    logic signed [2*`PIPE_XLEN+1:0] product;

    // One extra bit turns the unsigned case into a signed multiply.
    assign a_ext   = {mul_signed & mul_a[`PIPE_XLEN-1], mul_a};
    assign b_ext   = {mul_signed & mul_b[`PIPE_XLEN-1], mul_b};
    assign product = a_ext * b_ext;

    // Loaded as the instruction enters the memory stage.
    always_ff @(posedge clk) begin
        if (mul_go) begin
            mul_result <= product[2*`PIPE_XLEN-1:0];
        end
    end

endmodule

// File: src/exe_stage.sv
`include "pipe_params.svh"

module exe_stage
    import op_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  logic [`PIPE_XLEN-1:0]    in_pc,
    input  inst_class_e              in_cls,
    input  op_u                      in_op,
    input  logic [`PIPE_XLEN-1:0]    in_rj_val,
    input  logic [`PIPE_XLEN-1:0]    in_rk_val,
    input  logic [`PIPE_XLEN-1:0]    in_imm,
    input  logic [`PIPE_RADDR_W-1:0] in_dest,
    ex_mem_if.master                 ex_mem,
    output logic                     sram_en,
    output logic [3:0]               sram_we,
    output logic [`DSRAM_AW-1:0]     sram_addr,
    output logic [`PIPE_XLEN-1:0]    sram_wdata,
    output logic [`PIPE_XLEN-1:0]    mul_a,
    output logic [`PIPE_XLEN-1:0]    mul_b,
    output logic                     mul_signed,
    output logic                     mul_go
);

    logic                     exe_valid;
    logic [`PIPE_XLEN-1:0]    exe_pc;
    inst_class_e              exe_cls;
    op_u                      exe_op;
    logic [`PIPE_XLEN-1:0]    exe_rj;
    logic [`PIPE_XLEN-1:0]    exe_rk;
    logic [`PIPE_XLEN-1:0]    exe_imm;
    logic [`PIPE_RADDR_W-1:0] exe_dest;

    logic [`PIPE_XLEN-1:0]    alu_out;
    logic [`PIPE_XLEN-1:0]    exe_addr;
    logic                     is_mem;
    logic                     is_store;
    logic                     advance;
    logic [3:0]               st_strb;
    logic                     misaligned;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_allowin   = ~exe_valid | ex_mem.allowin;
    assign advance      = exe_valid & ex_mem.allowin;  // Instruction leaves this cycle.
    assign ex_mem.valid = exe_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else if (in_allowin) begin
            exe_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            exe_pc   <= in_pc;
            exe_cls  <= in_cls;
            exe_op   <= in_op;
            exe_rj   <= in_rj_val;
            exe_rk   <= in_rk_val;
            exe_imm  <= in_imm;
            exe_dest <= in_dest;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU and address generation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (exe_op.alu)
            ALU_ADD:  alu_out = exe_rj + exe_rk;
            ALU_SUB:  alu_out = exe_rj - exe_rk;
            ALU_AND:  alu_out = exe_rj & exe_rk;
            ALU_OR:   alu_out = exe_rj | exe_rk;
            ALU_XOR:  alu_out = exe_rj ^ exe_rk;
            ALU_SLT:  alu_out = {31'd0, $signed(exe_rj) < $signed(exe_rk)};
            ALU_SLTU: alu_out = {31'd0, exe_rj < exe_rk};
            ALU_SLL:  alu_out = exe_rj << exe_rk[4:0];
            ALU_SRL:  alu_out = exe_rj >> exe_rk[4:0];
            default:  alu_out = '0;  // Multiply results come from the multiplier.
        endcase
    end

    assign exe_addr = exe_rj + exe_imm;
    assign is_mem   = (exe_cls == CLS_LOAD) || (exe_cls == CLS_STORE);
    assign is_store = (exe_cls == CLS_STORE);

    assign ex_mem.data = '{
        pc:         exe_pc,
        rf_we:      !is_store && (exe_dest != '0),
        rf_waddr:   exe_dest,
        alu_result: is_mem ? exe_addr : alu_out,
        cls:        exe_cls,
        op:         exe_op,
        mul_high:   (exe_op.alu == MUL_H) || (exe_op.alu == MUL_HU)
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM and multiplier requests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (exe_op.mem.size)
            SZ_BYTE: begin
                st_strb    = 4'b0001 << exe_addr[1:0];
                sram_wdata = {4{exe_rk[7:0]}};
            end
            SZ_HALF: begin
                st_strb    = 4'b0011 << {exe_addr[1], 1'b0};
                sram_wdata = {2{exe_rk[15:0]}};
            end
            default: begin
                st_strb    = 4'b1111;
                sram_wdata = exe_rk;
            end
        endcase
    end

    assign sram_en   = advance & is_mem;
    assign sram_we   = (advance & is_store) ? st_strb : 4'b0000;
    assign sram_addr = exe_addr[`DSRAM_AW+1:2];

    assign mul_a      = exe_rj;
    assign mul_b      = exe_rk;
    assign mul_signed = (exe_op.alu != MUL_HU);  // The low word is the same either way.
    assign mul_go     = advance & (exe_cls == CLS_MUL);

    assign misaligned = ((exe_op.mem.size == SZ_HALF) && exe_addr[0]) ||
                        ((exe_op.mem.size == SZ_WORD) && (exe_addr[1:0] != 2'b00));

    // A misaligned access would reach the SRAM with wrong strobes.
    a_aligned: assert property (@(posedge clk) disable iff (!resetn)
        exe_valid && is_mem |-> !misaligned)
        else $error("misaligned access at pc %h", exe_pc);

endmodule

// File: common/stage_if.sv
// Execute to memory handshake.
interface ex_mem_if
    import pipe_pkg::*;
();

    logic    valid;
    logic    allowin;
    ex_mem_t data;

    modport master (
        output valid,
        output data,
        input  allowin
    );

    modport slave (
        input  valid,
        input  data,
        output allowin
    );

endinterface

// Memory to write-back handshake.
interface mem_wb_if
    import pipe_pkg::*;
();

    logic    valid;
    logic    allowin;
    mem_wb_t data;

    modport master (
        output valid,
        output data,
        input  allowin
    );

    modport slave (
        input  valid,
        input  data,
        output allowin
    );

endinterface

// File: common/pipe_pkg.sv
`include "pipe_params.svh"

package pipe_pkg;

    import op_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payloads carried between the stages.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
        logic [`PIPE_XLEN-1:0]    alu_result;  // Byte address for loads and stores.
        inst_class_e              cls;
        op_u                      op;
        logic                     mul_high;    // Take the upper product word.
    } ex_mem_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
        logic [`PIPE_XLEN-1:0]    rf_wdata;
    } mem_wb_t;

endpackage

// File: common/op_pkg.sv
package op_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction classes and operation encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        CLS_ALU   = 2'd0,
        CLS_LOAD  = 2'd1,
        CLS_STORE = 2'd2,
        CLS_MUL   = 2'd3
    } inst_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        MUL_LO   = 4'd9,   // Low word of the product.
        MUL_H    = 4'd10,  // Signed high word.
        MUL_HU   = 4'd11   // Unsigned high word.
    } alu_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic      spare;
        logic      zero_ext;  // Only meaningful for loads.
        mem_size_e size;
    } mem_acc_t;

    // ALU and multiply classes read the op word as alu, memory classes as mem.
    typedef union packed {
        alu_op_e  alu;
        mem_acc_t mem;
    } op_u;

endpackage

// File: common/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Width of every data path word.
`define PIPE_XLEN 32

// Register file address width.
`define PIPE_RADDR_W 5

// Word address width of the data SRAM (256 words).
`define DSRAM_AW 8

`endif
